//--- Makefile
# Verilator flow for the memory stage

VERILATOR ?= verilator
FILELIST  ?= mem_stage.f
RTL_TOP   ?= mem_stage
TB_TOP    ?= mem_stage_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TB_TOP)
	./$(BUILD_DIR)/$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "no pass line found in $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/load_writeback.sv
// ********************
// load extraction and writeback value select
// output gating while memory is stalled
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module load_writeback (
    input  wire                            r_valid,
    input  wire rv_isa_pkg::xlen_t         r_pc,
    input  wire rv_isa_pkg::inst_t         r_inst,
    input  wire mem_stage_pkg::mem_op_t    r_mem_op,
    input  wire mem_stage_pkg::wb_sel_t    r_wb_sel,
    input  wire rv_isa_pkg::xlen_t         r_alu,
    input  wire rv_isa_pkg::xlen_t         r_src2,
    input  wire rv_isa_pkg::xlen_t         mem_rdata,   // valid on the ready cycle
    input  wire                            mem_stall,
    output logic                           out_valid,
    output rv_isa_pkg::xlen_t              out_pc,
    output rv_isa_pkg::inst_t              out_inst,
    output logic                           reg_wen,
    output rv_isa_pkg::reg_idx_t           reg_rd,
    output rv_isa_pkg::xlen_t              reg_value
);

    logic              live;        // valid and not waiting on memory
    logic [2:0]        off;
    logic [7:0]        ld_b;
    logic [15:0]       ld_h;
    logic [31:0]       ld_w;
    logic              ld_sext;     // signed load variants
    rv_isa_pkg::xlen_t ld_ext;
    rv_isa_pkg::xlen_t wb_value;

    assign live = r_valid && !mem_stall;
    assign off  = r_alu[2:0];

    // ********************
    // load extraction
    // ********************
    assign ld_b    = mem_rdata[{off, 3'b000} +: 8];
    assign ld_h    = mem_rdata[{off[2:1], 4'b0000} +: 16];
    assign ld_w    = mem_rdata[{off[2], 5'b00000} +: 32];
    assign ld_sext = !(r_mem_op inside {mem_stage_pkg::MOP_LBU, mem_stage_pkg::MOP_LHU,
                                        mem_stage_pkg::MOP_LWU});

    always_comb begin
        case (mem_stage_pkg::access_size(r_mem_op))
            2'd0:    ld_ext = {{(`XLEN-8){ld_sext & ld_b[7]}}, ld_b};
            2'd1:    ld_ext = off[0] ? '0                          // misaligned lh/lhu
                                     : {{(`XLEN-16){ld_sext & ld_h[15]}}, ld_h};
            2'd2:    ld_ext = {{(`XLEN-32){ld_sext & ld_w[31]}}, ld_w};
            default: ld_ext = mem_rdata;                            // ld, whole beat
        endcase
        if (!mem_stage_pkg::is_load(r_mem_op)) begin
            ld_ext = '0;
        end
    end

    // ********************
    // writeback select
    // ********************
    always_comb begin
        case (r_wb_sel)
            mem_stage_pkg::WB_ALU:  wb_value = r_alu;
            mem_stage_pkg::WB_PC4:  wb_value = r_pc + rv_isa_pkg::xlen_t'(4);  // link addr
            mem_stage_pkg::WB_LOAD: wb_value = ld_ext;
            mem_stage_pkg::WB_SRC2: wb_value = r_src2;  // old csr value
            default:                wb_value = '0;
        endcase
    end

    // nothing leaves while the entry is empty or memory is pending
    assign out_valid = live;
    assign out_pc    = live ? r_pc : '0;
    assign out_inst  = live ? r_inst : '0;
    assign reg_wen   = live && (r_wb_sel != mem_stage_pkg::WB_NONE);
    assign reg_rd    = live ? rv_isa_pkg::rd_of(r_inst) : '0;
    assign reg_value = live ? wb_value : '0;

endmodule

`default_nettype wire

//--- design/mem_request.sv
// ********************
// memory request builder
// store forwarding, strobe and data alignment, stall
// ********************

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_config.svh"

module mem_request (
    input  wire                            r_valid,
    input  wire rv_isa_pkg::inst_t         r_inst,
    input  wire mem_stage_pkg::mem_op_t    r_mem_op,
    input  wire rv_isa_pkg::xlen_t         r_alu,
    input  wire rv_isa_pkg::xlen_t         r_src2,
    input  wire                            wb_valid,    // WB stage occupancy
    input  wire rv_isa_pkg::inst_t         wb_inst,
    input  wire rv_isa_pkg::xlen_t         wb_wdata,
    input  wire                            mem_ready,
    output logic                           mem_req,
    output logic                           mem_we,
    output rv_isa_pkg::xlen_t              mem_addr,
    output rv_isa_pkg::xlen_t              mem_wdata,
    output mem_stage_pkg::strb_t           mem_wstrb,
    output logic                           mem_stall
);

    logic              st_live;   // valid store in the register
    logic              fwd_hit;
    logic [2:0]        off;       // byte lane in the dword
    rv_isa_pkg::xlen_t st_data;   // src2 after forwarding

    // ********************
    // request and stall
    // ********************
    assign st_live   = r_valid && mem_stage_pkg::is_store(r_mem_op);
    assign mem_req   = r_valid && (mem_stage_pkg::is_load(r_mem_op) || st_live);
    assign mem_we    = st_live;
    assign mem_addr  = r_alu;                       // address straight from the ALU
    assign mem_stall = mem_req && !mem_ready;       // level, clears on the ready cycle
    assign off       = r_alu[2:0];

    // ********************
    // store operand forwarding
    // ********************
    // load-use on rs2 of a store, value only just arriving in WB
    assign fwd_hit = st_live && wb_valid
                   && rv_isa_pkg::writes_rd(wb_inst)
                   && (rv_isa_pkg::rd_of(wb_inst) == rv_isa_pkg::rs2_of(r_inst))
                   && (rv_isa_pkg::rs2_of(r_inst) != '0);   // x0 never forwards

    assign st_data = fwd_hit ? wb_wdata : r_src2;

    // ********************
    // lane alignment
    // ********************
    always_comb begin
        mem_wdata = '0;
        mem_wstrb = '0;
        if (st_live) begin
            case (mem_stage_pkg::access_size(r_mem_op))
                2'd0: begin     // sb, any lane
                    mem_wstrb = mem_stage_pkg::strb_t'(1) << off;
                    mem_wdata = {{(`XLEN-8){1'b0}}, st_data[7:0]} << {off, 3'b000};
                end
                2'd1: begin     // sh, odd lanes unsupported -> zero strobe
                    if (!off[0]) begin
                        mem_wstrb = mem_stage_pkg::strb_t'(3) << off;
                        mem_wdata = {{(`XLEN-16){1'b0}}, st_data[15:0]} << {off, 3'b000};
                    end
                end
                2'd2: begin     // sw, upper or lower half by bit 2
                    mem_wstrb = off[2] ? 8'hf0 : 8'h0f;
                    mem_wdata = off[2] ? {st_data[31:0], 32'b0} : {32'b0, st_data[31:0]};
                end
                default: begin  // sd
                    mem_wstrb = '1;
                    mem_wdata = st_data;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/mem_stage.sv
// ********************
// rv64 memory stage top
// stage register, request builder, load/writeback
// ********************

`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                            clk,
    input  wire                            rst,
    // from execute
    input  wire                            in_valid,
    output logic                           in_ready,
    input  wire rv_isa_pkg::xlen_t         in_pc,
    input  wire rv_isa_pkg::inst_t         in_inst,
    input  wire mem_stage_pkg::mem_op_t    in_mem_op,
    input  wire mem_stage_pkg::wb_sel_t    in_wb_sel,
    input  wire rv_isa_pkg::xlen_t         in_alu,
    input  wire rv_isa_pkg::xlen_t         in_src2,
    // to writeback
    output logic                           out_valid,
    input  wire                            out_ready,
    output rv_isa_pkg::xlen_t              out_pc,
    output rv_isa_pkg::inst_t              out_inst,
    output logic                           reg_wen,
    output rv_isa_pkg::reg_idx_t           reg_rd,
    output rv_isa_pkg::xlen_t              reg_value,
    // forwarding source in WB
    input  wire                            wb_valid,
    input  wire rv_isa_pkg::inst_t         wb_inst,
    input  wire rv_isa_pkg::xlen_t         wb_wdata,
    // memory port
    output logic                           mem_req,
    output logic                           mem_we,
    output rv_isa_pkg::xlen_t              mem_addr,
    output rv_isa_pkg::xlen_t              mem_wdata,
    output mem_stage_pkg::strb_t           mem_wstrb,
    input  wire rv_isa_pkg::xlen_t         mem_rdata,
    input  wire                            mem_ready
);

    // register contents shared by both halves
    logic                   r_valid;
    rv_isa_pkg::xlen_t      r_pc;
    rv_isa_pkg::inst_t      r_inst;
    mem_stage_pkg::mem_op_t r_mem_op;
    mem_stage_pkg::wb_sel_t r_wb_sel;
    rv_isa_pkg::xlen_t      r_alu;
    rv_isa_pkg::xlen_t      r_src2;
    logic                   mem_stall;  // from the request side only

    stage_reg u_stage_reg (
        .clk       (clk),       .rst      (rst),
        .in_valid  (in_valid),  .in_pc    (in_pc),     .in_inst  (in_inst),
        .in_mem_op (in_mem_op), .in_wb_sel(in_wb_sel), .in_alu   (in_alu),
        .in_src2   (in_src2),   .out_ready(out_ready), .mem_stall(mem_stall),
        .in_ready  (in_ready),  .r_valid  (r_valid),   .r_pc     (r_pc),
        .r_inst    (r_inst),    .r_mem_op (r_mem_op),  .r_wb_sel (r_wb_sel),
        .r_alu     (r_alu),     .r_src2   (r_src2)
    );

    mem_request u_mem_request (
        .r_valid  (r_valid),  .r_inst   (r_inst),   .r_mem_op (r_mem_op),
        .r_alu    (r_alu),    .r_src2   (r_src2),
        .wb_valid (wb_valid), .wb_inst  (wb_inst),  .wb_wdata (wb_wdata),
        .mem_ready(mem_ready),
        .mem_req  (mem_req),  .mem_we   (mem_we),   .mem_addr (mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_stall(mem_stall)
    );

    load_writeback u_load_writeback (
        .r_valid  (r_valid),  .r_pc     (r_pc),     .r_inst   (r_inst),
        .r_mem_op (r_mem_op), .r_wb_sel (r_wb_sel), .r_alu    (r_alu),
        .r_src2   (r_src2),   .mem_rdata(mem_rdata), .mem_stall(mem_stall),
        .out_valid(out_valid), .out_pc  (out_pc),   .out_inst (out_inst),
        .reg_wen  (reg_wen),  .reg_rd   (reg_rd),   .reg_value(reg_value)
    );

endmodule

`default_nettype wire

//--- design/mem_stage_config.svh
// ********************
// width macros for the rv64 memory stage
// data word, instruction, register index, byte strobes
// ********************

`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// ********************
// datapath widths
// ********************

// one integer register / one memory beat
`define XLEN    64

// base isa only, no compressed encodings
`define ILEN    32

// x0..x31
`define REG_AW  5

// ********************
// memory port
// ********************

// one strobe per byte of XLEN
`define STRB_W  8

`endif

//--- design/mem_stage_pkg.sv
// ********************
// memory stage control encodings
// memory op, writeback select, strobes, size helpers
// ********************

`default_nettype none

`include "mem_stage_config.svh"

package mem_stage_pkg;

    // replaces the wide one-hot-ish opcode from execute
    typedef enum logic [3:0] {
        MOP_NONE = 4'd0,
        MOP_LB   = 4'd1,
        MOP_LH   = 4'd2,
        MOP_LW   = 4'd3,
        MOP_LD   = 4'd4,
        MOP_LBU  = 4'd5,
        MOP_LHU  = 4'd6,
        MOP_LWU  = 4'd7,
        MOP_SB   = 4'd8,
        MOP_SH   = 4'd9,
        MOP_SW   = 4'd10,
        MOP_SD   = 4'd11
    } mem_op_t;

    // where the rd value comes from
    typedef enum logic [2:0] {
        WB_NONE = 3'd0,   // no gpr write
        WB_ALU  = 3'd1,
        WB_PC4  = 3'd2,   // jal/jalr link
        WB_LOAD = 3'd3,
        WB_SRC2 = 3'd4    // csr read value rides in src2
    } wb_sel_t;

    typedef logic [`STRB_W-1:0] strb_t;

    function automatic logic is_load(input mem_op_t op);
        return (op >= MOP_LB) && (op <= MOP_LWU);
    endfunction

    function automatic logic is_store(input mem_op_t op);
        return (op >= MOP_SB) && (op <= MOP_SD);
    endfunction

    // log2 of access bytes, 0 byte .. 3 dword
    function automatic logic [1:0] access_size(input mem_op_t op);
        logic [1:0] sz;
        case (op)
            MOP_LB, MOP_LBU, MOP_SB: sz = 2'd0;
            MOP_LH, MOP_LHU, MOP_SH: sz = 2'd1;
            MOP_LW, MOP_LWU, MOP_SW: sz = 2'd2;
            default:                 sz = 2'd3;  // ld / sd
        endcase
        return sz;
    endfunction

endpackage

`default_nettype wire

//--- design/rv_isa_pkg.sv
// ********************
// rv64 instruction field types and major opcodes
// rd / rs2 extraction and the writes-rd classifier
// ********************

`default_nettype none

`include "mem_stage_config.svh"

package rv_isa_pkg;

    // ********************
    // basic types
    // ********************
    typedef logic [`XLEN-1:0]   xlen_t;     // data word
    typedef logic [`ILEN-1:0]   inst_t;     // raw instruction
    typedef logic [`REG_AW-1:0] reg_idx_t;  // gpr index
    typedef logic [6:0]         opcode_t;   // inst[6:0]

    // major opcodes, only the ones the stage looks at
    localparam opcode_t OPC_LOAD      = 7'b0000011;
    localparam opcode_t OPC_STORE     = 7'b0100011;
    localparam opcode_t OPC_OP_IMM    = 7'b0010011;
    localparam opcode_t OPC_OP_IMM_32 = 7'b0011011;
    localparam opcode_t OPC_OP        = 7'b0110011;
    localparam opcode_t OPC_OP_32     = 7'b0111011;
    localparam opcode_t OPC_LUI       = 7'b0110111;
    localparam opcode_t OPC_AUIPC     = 7'b0010111;
    localparam opcode_t OPC_SYSTEM    = 7'b1110011;

    // ********************
    // field extraction
    // ********************
    function automatic opcode_t opcode_of(input inst_t inst);
        return inst[6:0];
    endfunction

    function automatic reg_idx_t rd_of(input inst_t inst);
        return inst[11:7];
    endfunction

    function automatic reg_idx_t rs2_of(input inst_t inst);
        return inst[24:20];
    endfunction

    // true for every class that puts a result in rd
    // jal / jalr deliberately left out, same as the forwarding source table
    function automatic logic writes_rd(input inst_t inst);
        logic [2:0] funct3;
        logic       hit;
        funct3 = inst[14:12];
        case (opcode_of(inst))
            OPC_OP_IMM, OPC_OP_IMM_32: hit = 1'b1;   // addi.. / addiw..
            OPC_OP, OPC_OP_32:         hit = 1'b1;   // reg-reg incl. mul/div
            OPC_LOAD:                  hit = 1'b1;
            OPC_LUI, OPC_AUIPC:        hit = 1'b1;
            OPC_SYSTEM:                hit = (funct3 == 3'b001) || (funct3 == 3'b010); // csrrw/csrrs
            OPC_STORE:                 hit = 1'b0;   // stores never write rd
            default:                   hit = 1'b0;
        endcase
        return hit;
    endfunction

endpackage

`default_nettype wire

//--- design/stage_reg.sv
// ********************
// EX/MEM pipeline register
// loads on in_ready, holds under stall or back-pressure
// ********************

`timescale 1ns/1ps
`default_nettype none

module stage_reg (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            in_valid,
    input  wire rv_isa_pkg::xlen_t         in_pc,
    input  wire rv_isa_pkg::inst_t         in_inst,
    input  wire mem_stage_pkg::mem_op_t    in_mem_op,
    input  wire mem_stage_pkg::wb_sel_t    in_wb_sel,
    input  wire rv_isa_pkg::xlen_t         in_alu,
    input  wire rv_isa_pkg::xlen_t         in_src2,
    input  wire                            out_ready,   // downstream can take it
    input  wire                            mem_stall,   // memory still busy
    output logic                           in_ready,
    output logic                           r_valid,
    output rv_isa_pkg::xlen_t              r_pc,
    output rv_isa_pkg::inst_t              r_inst,
    output mem_stage_pkg::mem_op_t         r_mem_op,
    output mem_stage_pkg::wb_sel_t         r_wb_sel,
    output rv_isa_pkg::xlen_t              r_alu,
    output rv_isa_pkg::xlen_t              r_src2
);

    // advance only when memory is done and WB accepts
    assign in_ready = !mem_stall && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            r_valid  <= 1'b0;
            r_pc     <= '0;
            r_inst   <= '0;
            r_mem_op <= mem_stage_pkg::MOP_NONE;
            r_wb_sel <= mem_stage_pkg::WB_NONE;
            r_alu    <= '0;
            r_src2   <= '0;
        end else if (in_ready) begin
            r_valid  <= in_valid;       // bubble loads as invalid
            r_pc     <= in_pc;
            r_inst   <= in_inst;
            r_mem_op <= in_mem_op;
            r_wb_sel <= in_wb_sel;
            r_alu    <= in_alu;         // also the memory address
            r_src2   <= in_src2;        // store data / csr value
        end
        // else hold everything
    end

endmodule

`default_nettype wire

//--- mem_stage.f
+incdir+design
design/rv_isa_pkg.sv
design/mem_stage_pkg.sv
design/stage_reg.sv
design/mem_request.sv
design/load_writeback.sv
design/mem_stage.sv
verif/mem_stage_tb.sv

//--- verif/mem_stage_tb.sv
// ********************
// testbench for the rv64 memory stage
// stimulus table, memory responder, check tasks, watchdog
// ********************

`timescale 1ns/1ps
`default_nettype none

module mem_stage_tb;

    typedef struct {
        string                  name;
        mem_stage_pkg::mem_op_t op;
        mem_stage_pkg::wb_sel_t sel;
        rv_isa_pkg::inst_t      inst;
        rv_isa_pkg::xlen_t      pc;
        rv_isa_pkg::xlen_t      alu;
        rv_isa_pkg::xlen_t      src2;
        logic                   wbv;        // forwarding stage
        rv_isa_pkg::inst_t      wbi;
        rv_isa_pkg::xlen_t      wbd;
        rv_isa_pkg::xlen_t      rdata;      // memory read word
        logic                   e_wen;
        rv_isa_pkg::reg_idx_t   e_rd;
        rv_isa_pkg::xlen_t      e_val;
        logic                   e_req;      // memory port level
        logic                   e_we;
        mem_stage_pkg::strb_t   e_strb;
        rv_isa_pkg::xlen_t      e_wdata;
    } test_t;

    localparam rv_isa_pkg::xlen_t RWORD = 64'h7F80_1234_8765_00FF; // b7..b0
    localparam rv_isa_pkg::xlen_t SDATA = 64'h0123_4567_89AB_CDEF; // store operand
    localparam rv_isa_pkg::xlen_t FDATA = 64'hFEED_FACE_CAFE_F00D; // forwarded value

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic in_valid = 1'b0;
    logic in_ready;
    rv_isa_pkg::xlen_t in_pc = '0;
    rv_isa_pkg::inst_t in_inst = '0;
    mem_stage_pkg::mem_op_t in_mem_op = mem_stage_pkg::MOP_NONE;
    mem_stage_pkg::wb_sel_t in_wb_sel = mem_stage_pkg::WB_NONE;
    rv_isa_pkg::xlen_t in_alu = '0;
    rv_isa_pkg::xlen_t in_src2 = '0;
    logic out_valid;
    logic out_ready = 1'b0;
    rv_isa_pkg::xlen_t out_pc;
    rv_isa_pkg::inst_t out_inst;
    logic reg_wen;
    rv_isa_pkg::reg_idx_t reg_rd;
    rv_isa_pkg::xlen_t reg_value;
    logic wb_valid = 1'b0;
    rv_isa_pkg::inst_t wb_inst = '0;
    rv_isa_pkg::xlen_t wb_wdata = '0;
    logic mem_req;
    logic mem_we;
    rv_isa_pkg::xlen_t mem_addr;
    rv_isa_pkg::xlen_t mem_wdata;
    mem_stage_pkg::strb_t mem_wstrb;
    rv_isa_pkg::xlen_t mem_rdata = '0;
    logic mem_ready = 1'b0;

    test_t tbl[$];
    int    errors = 0;
    int    out_cnt = 0;
    logic  adv = 1'b0;      // register reloads at the coming edge
    logic  built = 1'b0;
    int    delay = 0;

    mem_stage UUT (.*);

    always #4 clk = ~clk;   // 8 ns period

    // ********************
    // table helpers
    // ********************
    function automatic rv_isa_pkg::inst_t enc(input logic [6:0] opc, input logic [4:0] rd,
                                              input logic [4:0] rs2, input logic [2:0] f3);
        return {7'b0, rs2, 5'd0, f3, rd, opc};
    endfunction

    task automatic add_entry(input string name, input mem_stage_pkg::mem_op_t op,
                             input mem_stage_pkg::wb_sel_t sel, input rv_isa_pkg::inst_t inst,
                             input rv_isa_pkg::xlen_t alu, input rv_isa_pkg::xlen_t src2,
                             input logic wbv, input rv_isa_pkg::inst_t wbi,
                             input rv_isa_pkg::xlen_t wbd, input logic e_wen,
                             input rv_isa_pkg::xlen_t e_val, input mem_stage_pkg::strb_t e_strb,
                             input rv_isa_pkg::xlen_t e_wdata);
        test_t t;
        t.name = name;
        t.op = op;
        t.sel = sel;
        t.inst = inst;
        t.pc = 64'h8000_0000 + 64'(4 * tbl.size());    // unique pc per entry
        t.alu = alu;
        t.src2 = src2;
        t.wbv = wbv;
        t.wbi = wbi;
        t.wbd = wbd;
        t.rdata = RWORD;
        t.e_wen = e_wen;
        t.e_rd = inst[11:7];
        t.e_val = e_val;
        t.e_req = (op != mem_stage_pkg::MOP_NONE);     // every load and store requests
        t.e_we = op inside {mem_stage_pkg::MOP_SB, mem_stage_pkg::MOP_SH,
                            mem_stage_pkg::MOP_SW, mem_stage_pkg::MOP_SD};
        t.e_strb = e_strb;
        t.e_wdata = e_wdata;
        tbl.push_back(t);
    endtask

    // load into x10 at 0x1000 + off
    task automatic add_load(input string name, input mem_stage_pkg::mem_op_t op,
                            input int off, input rv_isa_pkg::xlen_t e_val);
        add_entry(name, op, mem_stage_pkg::WB_LOAD, enc(7'b0000011, 5'd10, 5'd0, 3'd0),
                  64'h1000 + 64'(off), '0, 1'b0, '0, '0, 1'b1, e_val, '0, '0);
    endtask

    // store of SDATA from x12, no forwarding
    task automatic add_store(input string name, input mem_stage_pkg::mem_op_t op,
                             input int off, input mem_stage_pkg::strb_t strb,
                             input rv_isa_pkg::xlen_t wdata);
        add_entry(name, op, mem_stage_pkg::WB_NONE, enc(7'b0100011, 5'd0, 5'd12, 3'd0),
                  64'h2000 + 64'(off), SDATA, 1'b0, '0, '0, 1'b0, '0, strb, wdata);
    endtask

    // sd at offset 0 with a WB-stage instruction alongside
    task automatic add_fwd(input string name, input logic [4:0] rs2, input logic wbv,
                           input rv_isa_pkg::inst_t wbi, input rv_isa_pkg::xlen_t wdata);
        add_entry(name, mem_stage_pkg::MOP_SD, mem_stage_pkg::WB_NONE,
                  enc(7'b0100011, 5'd0, rs2, 3'd0), 64'h3000, SDATA, wbv, wbi, FDATA,
                  1'b0, '0, 8'hFF, wdata);
    endtask

    task automatic build_table();
        // non-memory writeback select
        add_entry("wb_alu", mem_stage_pkg::MOP_NONE, mem_stage_pkg::WB_ALU,
                  enc(7'b0010011, 5'd5, 5'd0, 3'd0), 64'h1234_5678_9ABC_DEF0, '0,
                  1'b0, '0, '0, 1'b1, 64'h1234_5678_9ABC_DEF0, '0, '0);
        add_entry("wb_pc4", mem_stage_pkg::MOP_NONE, mem_stage_pkg::WB_PC4,
                  enc(7'b1101111, 5'd1, 5'd0, 3'd0), 64'h55, '0,
                  1'b0, '0, '0, 1'b1, 64'h8000_0008, '0, '0);   // pc 0x8000_0004
        add_entry("wb_src2", mem_stage_pkg::MOP_NONE, mem_stage_pkg::WB_SRC2,
                  enc(7'b1110011, 5'd7, 5'd0, 3'd2), 64'h300, 64'hDEAD_BEEF_0000_0001,
                  1'b0, '0, '0, 1'b1, 64'hDEAD_BEEF_0000_0001, '0, '0);
        add_entry("wb_none", mem_stage_pkg::MOP_NONE, mem_stage_pkg::WB_NONE,
                  enc(7'b1100011, 5'd9, 5'd3, 3'd0), 64'h77, 64'h88,
                  1'b0, '0, '0, 1'b0, '0, '0, '0);
        // loads, RWORD bytes FF 00 65 87 34 12 80 7F from lane 0
        add_load("lb_0", mem_stage_pkg::MOP_LB, 0, 64'hFFFF_FFFF_FFFF_FFFF);
        add_load("lb_1", mem_stage_pkg::MOP_LB, 1, 64'h0);
        add_load("lb_2", mem_stage_pkg::MOP_LB, 2, 64'h65);
        add_load("lb_3", mem_stage_pkg::MOP_LB, 3, 64'hFFFF_FFFF_FFFF_FF87);
        add_load("lb_4", mem_stage_pkg::MOP_LB, 4, 64'h34);
        add_load("lb_5", mem_stage_pkg::MOP_LB, 5, 64'h12);
        add_load("lb_6", mem_stage_pkg::MOP_LB, 6, 64'hFFFF_FFFF_FFFF_FF80);
        add_load("lb_7", mem_stage_pkg::MOP_LB, 7, 64'h7F);
        add_load("lbu_0", mem_stage_pkg::MOP_LBU, 0, 64'hFF);
        add_load("lbu_6", mem_stage_pkg::MOP_LBU, 6, 64'h80);
        add_load("lh_0", mem_stage_pkg::MOP_LH, 0, 64'hFF);
        add_load("lh_2", mem_stage_pkg::MOP_LH, 2, 64'hFFFF_FFFF_FFFF_8765);
        add_load("lh_4", mem_stage_pkg::MOP_LH, 4, 64'h1234);
        add_load("lh_6", mem_stage_pkg::MOP_LH, 6, 64'h7F80);
        add_load("lh_1_misaligned", mem_stage_pkg::MOP_LH, 1, 64'h0);
        add_load("lhu_2", mem_stage_pkg::MOP_LHU, 2, 64'h8765);
        add_load("lhu_6", mem_stage_pkg::MOP_LHU, 6, 64'h7F80);
        add_load("lw_0", mem_stage_pkg::MOP_LW, 0, 64'hFFFF_FFFF_8765_00FF);
        add_load("lw_4", mem_stage_pkg::MOP_LW, 4, 64'h7F80_1234);
        add_load("lwu_0", mem_stage_pkg::MOP_LWU, 0, 64'h8765_00FF);
        add_load("lwu_4", mem_stage_pkg::MOP_LWU, 4, 64'h7F80_1234);
        add_load("ld_0", mem_stage_pkg::MOP_LD, 0, RWORD);
        // stores of SDATA
        add_store("sb_0", mem_stage_pkg::MOP_SB, 0, 8'h01, 64'hEF);
        add_store("sb_1", mem_stage_pkg::MOP_SB, 1, 8'h02, 64'h0000_0000_0000_EF00);
        add_store("sb_2", mem_stage_pkg::MOP_SB, 2, 8'h04, 64'h0000_0000_00EF_0000);
        add_store("sb_3", mem_stage_pkg::MOP_SB, 3, 8'h08, 64'h0000_0000_EF00_0000);
        add_store("sb_4", mem_stage_pkg::MOP_SB, 4, 8'h10, 64'h0000_00EF_0000_0000);
        add_store("sb_5", mem_stage_pkg::MOP_SB, 5, 8'h20, 64'h0000_EF00_0000_0000);
        add_store("sb_6", mem_stage_pkg::MOP_SB, 6, 8'h40, 64'h00EF_0000_0000_0000);
        add_store("sb_7", mem_stage_pkg::MOP_SB, 7, 8'h80, 64'hEF00_0000_0000_0000);
        add_store("sh_0", mem_stage_pkg::MOP_SH, 0, 8'h03, 64'hCDEF);
        add_store("sh_2", mem_stage_pkg::MOP_SH, 2, 8'h0C, 64'h0000_0000_CDEF_0000);
        add_store("sh_4", mem_stage_pkg::MOP_SH, 4, 8'h30, 64'h0000_CDEF_0000_0000);
        add_store("sh_6", mem_stage_pkg::MOP_SH, 6, 8'hC0, 64'hCDEF_0000_0000_0000);
        add_store("sh_3_misaligned", mem_stage_pkg::MOP_SH, 3, 8'h00, 64'h0);
        add_store("sw_0", mem_stage_pkg::MOP_SW, 0, 8'h0F, 64'h89AB_CDEF);
        add_store("sw_4", mem_stage_pkg::MOP_SW, 4, 8'hF0, 64'h89AB_CDEF_0000_0000);
        add_store("sd_0", mem_stage_pkg::MOP_SD, 0, 8'hFF, SDATA);
        // forwarding into the store operand
        add_fwd("fwd_op_hit", 5'd12, 1'b1, enc(7'b0110011, 5'd12, 5'd1, 3'd0), FDATA);
        add_fwd("fwd_load_hit", 5'd12, 1'b1, enc(7'b0000011, 5'd12, 5'd0, 3'd3), FDATA);
        add_fwd("fwd_x0", 5'd0, 1'b1, enc(7'b0110011, 5'd0, 5'd1, 3'd0), SDATA);
        add_fwd("fwd_wb_idle", 5'd12, 1'b0, enc(7'b0110011, 5'd12, 5'd1, 3'd0), SDATA);
        add_fwd("fwd_wb_store", 5'd12, 1'b1, enc(7'b0100011, 5'd12, 5'd1, 3'd3), SDATA);
    endtask

    // ********************
    // check tasks
    // ********************
    task automatic check_wb(input string name, input logic exp_wen, input logic act_wen,
                            input rv_isa_pkg::reg_idx_t exp_rd, input rv_isa_pkg::reg_idx_t act_rd,
                            input rv_isa_pkg::xlen_t exp_val, input rv_isa_pkg::xlen_t act_val,
                            input rv_isa_pkg::xlen_t exp_pc, input rv_isa_pkg::xlen_t act_pc,
                            input rv_isa_pkg::inst_t exp_inst, input rv_isa_pkg::inst_t act_inst);
        if (act_pc !== exp_pc) begin
            errors++;
            $display("Fail %s out_pc expected %h actual %h", name, exp_pc, act_pc);
        end
        if (act_inst !== exp_inst) begin
            errors++;
            $display("Fail %s out_inst expected %h actual %h", name, exp_inst, act_inst);
        end
        if (act_wen !== exp_wen) begin
            errors++;
            $display("Fail %s reg_wen expected %0b actual %0b", name, exp_wen, act_wen);
        end
        if (act_rd !== exp_rd) begin
            errors++;
            $display("Fail %s reg_rd expected %0d actual %0d", name, exp_rd, act_rd);
        end
        if (act_val !== exp_val) begin
            errors++;
            $display("Fail %s reg_value expected %h actual %h", name, exp_val, act_val);
        end
    endtask

    task automatic check_store(input string name,
                               input logic exp_req, input logic act_req,
                               input logic exp_we, input logic act_we,
                               input rv_isa_pkg::xlen_t exp_addr,
                               input rv_isa_pkg::xlen_t act_addr,
                               input mem_stage_pkg::strb_t exp_strb,
                               input mem_stage_pkg::strb_t act_strb,
                               input rv_isa_pkg::xlen_t exp_data,
                               input rv_isa_pkg::xlen_t act_data);
        if (act_req !== exp_req) begin
            errors++;
            $display("Fail %s mem_req expected %0b actual %0b", name, exp_req, act_req);
        end
        if (act_we !== exp_we) begin
            errors++;
            $display("Fail %s mem_we expected %0b actual %0b", name, exp_we, act_we);
        end
        if (act_addr !== exp_addr) begin
            errors++;
            $display("Fail %s mem_addr expected %h actual %h", name, exp_addr, act_addr);
        end
        if (act_strb !== exp_strb) begin
            errors++;
            $display("Fail %s mem_wstrb expected %h actual %h", name, exp_strb, act_strb);
        end
        if (act_data !== exp_data) begin
            errors++;
            $display("Fail %s mem_wdata expected %h actual %h", name, exp_data, act_data);
        end
    endtask

    // ********************
    // memory responder and out_ready
    // ********************
    always @(negedge clk) adv <= !rst && in_ready;   // stable mid-cycle

    always @(posedge clk) begin
        #1;
        out_ready <= rst ? 1'b0 : (($urandom % 4) != 0);    // drop about one in four
        if (rst || adv) begin
            delay = $urandom % 4;                           // new request, 0..3 wait
            mem_ready <= (delay == 0);
        end else if (!mem_ready) begin
            delay = delay - 1;
            mem_ready <= (delay <= 0);
        end
    end

    // ********************
    // output monitor
    // ********************
    always @(negedge clk) begin
        if (!rst && built) begin
            if (!out_ready && in_ready) begin
                errors++;
                $display("in_ready high while out_ready is low at %0t", $time);
            end
            if (out_valid && out_ready) begin
                if (out_cnt >= tbl.size()) begin
                    errors++;
                    $display("unexpected extra output at %0t", $time);
                end else begin
                    check_wb(tbl[out_cnt].name, tbl[out_cnt].e_wen, reg_wen,
                             tbl[out_cnt].e_rd, reg_rd, tbl[out_cnt].e_val, reg_value,
                             tbl[out_cnt].pc, out_pc, tbl[out_cnt].inst, out_inst);
                    check_store(tbl[out_cnt].name, tbl[out_cnt].e_req, mem_req,
                                tbl[out_cnt].e_we, mem_we, tbl[out_cnt].alu, mem_addr,
                                tbl[out_cnt].e_strb, mem_wstrb,
                                tbl[out_cnt].e_wdata, mem_wdata);
                end
                out_cnt++;
            end
        end
    end

    // watchdog
    initial begin
        wait (built);
        repeat (tbl.size() * 12 + 50) @(posedge clk);
        $display("timeout, only %0d of %0d entries came out", out_cnt, tbl.size());
        $display("Regression failed");
        $finish;
    end

    // ********************
    // driver
    // ********************
    initial begin
        logic took;
        void'($urandom(90360));
        build_table();
        repeat (5) @(posedge clk);
        #1 rst <= 1'b0;
        @(negedge clk);
        if (out_valid || reg_wen || mem_req) begin
            errors++;
            $display("outputs not idle after reset");
        end
        built = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < tbl.size(); i++) begin
            in_valid = 1'b1;
            in_pc = tbl[i].pc;
            in_inst = tbl[i].inst;
            in_mem_op = tbl[i].op;
            in_wb_sel = tbl[i].sel;
            in_alu = tbl[i].alu;
            in_src2 = tbl[i].src2;
            do begin
                @(negedge clk);
                took = in_ready;
                @(posedge clk);
                #1;
            end while (!took);
            // entry i now sits in the register
            wb_valid = tbl[i].wbv;
            wb_inst = tbl[i].wbi;
            wb_wdata = tbl[i].wbd;
            mem_rdata = tbl[i].rdata;
        end
        in_valid = 1'b0;
        wait (out_cnt >= tbl.size());
        repeat (4) @(posedge clk);
        $display("errors: %0d, entries out: %0d of %0d", errors, out_cnt, tbl.size());
        if (errors == 0 && out_cnt == tbl.size()) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
